// ==== design/cone_point_cfg.svh ====
`ifndef CONE_POINT_CFG_SVH
`define CONE_POINT_CFG_SVH

// lanes in one row of the dot product
`define CP_LANES 12

// coordinates that make up one point
`define CP_COORDS 11

// operand and product width
`define CP_DATA_W 64

// numerator, diagonal and quotient width
`define CP_NUM_W 40

// one packed coordinate
`define CP_BYTE_W 8

// packed point word, top byte stays zero
`define CP_POINT_W 96

`endif

// ==== design/cone_point_pkg.sv ====
`include "cone_point_cfg.svh"

package cone_point_pkg;

	// 64-bit operand or lane product
	typedef logic [`CP_DATA_W-1:0] data_t;

	// signed numerator, diagonal or quotient
	typedef logic signed [`CP_NUM_W-1:0] num_t;

	// one coordinate byte of a point
	typedef logic [`CP_BYTE_W-1:0] coord_t;

	// packed point word as sent out
	typedef logic [`CP_POINT_W-1:0] point_t;

	typedef data_t [`CP_LANES-1:0] lanes_t; // lane 0 in the low word

	// completed points since reset
	typedef logic [31:0] count_t;

endpackage

// ==== design/row_dot_product.sv ====
`include "cone_point_cfg.svh"

module row_dot_product (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  row_valid,
	input  cone_point_pkg::lanes_t matrix_lanes,
	input  cone_point_pkg::lanes_t vector_lanes,
	input  cone_point_pkg::num_t   diagonal,
	output cone_point_pkg::data_t  outer_sum,
	output cone_point_pkg::num_t   diagonal_out,
	output logic                  sum_valid
);

	cone_point_pkg::data_t prod [`CP_LANES]; // first stage, one per lane
	cone_point_pkg::data_t pair_sum [`CP_LANES/2];
	cone_point_pkg::data_t tree_sum;
	cone_point_pkg::num_t  diag_q; // diagonal riding along with prod
	logic                  prod_valid;

	// stage one, parallel lane multiply (low 64 bits kept)
	always_ff @(posedge clk) begin
		if (row_valid) begin
			for (int i = 0; i < `CP_LANES; i++) begin
				prod[i] <= matrix_lanes[i] * vector_lanes[i];
			end
			diag_q <= diagonal;
		end
	end

	// adder tree, pairs first then the six partials
	always_comb begin
		for (int i = 0; i < `CP_LANES/2; i++) begin
			pair_sum[i] = prod[2*i] + prod[2*i+1];
		end
		tree_sum = '0;
		for (int i = 0; i < `CP_LANES/2; i++) begin
			tree_sum = tree_sum + pair_sum[i];
		end
	end

	// stage two, outer sum register
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			outer_sum    <= tree_sum;
			diagonal_out <= diag_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= row_valid;
			sum_valid  <= prod_valid; // lines up with outer_sum
		end
	end

endmodule

// ==== design/summand_multiplier.sv ====
module summand_multiplier (
	input  logic                 clk,
	input  cone_point_pkg::data_t hat_value,
	input  cone_point_pkg::data_t prime_value,
	output cone_point_pkg::data_t summand
);

	// hat times prime, low 64 bits only
	cone_point_pkg::data_t summand_prod;

	// free running, the dot product valid qualifies it downstream
	always_ff @(posedge clk) begin
		summand_prod <= hat_value * prime_value;
	end

	// second register so summand arrives with outer_sum
	always_ff @(posedge clk) begin
		summand <= summand_prod;
	end

endmodule

// ==== design/point_divider.sv ====
`include "cone_point_cfg.svh"

module point_divider (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sum_valid,
	input  cone_point_pkg::data_t  outer_sum,
	input  cone_point_pkg::data_t  summand,
	input  cone_point_pkg::num_t   diagonal,
	output cone_point_pkg::point_t point_word,
	output logic                   point_valid,
	output cone_point_pkg::count_t point_count
);

	localparam int LAST_SLOT = `CP_COORDS - 1;

	cone_point_pkg::data_t  raw_sum;
	cone_point_pkg::num_t   numerator;
	cone_point_pkg::num_t   trunc_quot;
	cone_point_pkg::num_t   trunc_rem;
	cone_point_pkg::num_t   floor_quot;
	cone_point_pkg::coord_t coords [`CP_COORDS];
	cone_point_pkg::coord_t next_coords [`CP_COORDS];
	logic [3:0]             slot; // next coordinate to write
	logic                   last_row;

	always_comb begin
		raw_sum   = outer_sum + summand;
		numerator = raw_sum[`CP_NUM_W-1:0]; // low 40 bits, read as signed
		trunc_quot = numerator / diagonal; // rounds toward zero
		trunc_rem  = numerator % diagonal; // takes the numerator's sign

		// step down one when truncation rounded up
		if (trunc_rem != '0 && (trunc_rem[`CP_NUM_W-1] != diagonal[`CP_NUM_W-1])) begin
			floor_quot = trunc_quot - cone_point_pkg::num_t'(1);
		end else begin
			floor_quot = trunc_quot;
		end

		for (int i = 0; i < `CP_COORDS; i++) begin
			next_coords[i] = coords[i];
		end
		next_coords[slot] = floor_quot[`CP_BYTE_W-1:0];
	end

	assign last_row = (slot == 4'(LAST_SLOT));

	// coordinate bytes, no reset needed
	always_ff @(posedge clk) begin
		if (sum_valid) begin
			for (int i = 0; i < `CP_COORDS; i++) begin
				coords[i] <= next_coords[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			slot        <= '0;
			point_valid <= 1'b0;
			point_count <= '0;
			point_word  <= '0;
		end else begin
			point_valid <= sum_valid && last_row;
			if (sum_valid) begin
				if (last_row) begin
					slot        <= '0;
					point_count <= point_count + 1'b1;
					point_word[`CP_POINT_W-1:`CP_COORDS*`CP_BYTE_W] <= '0; // top byte
					for (int i = 0; i < `CP_COORDS; i++) begin
						point_word[i*`CP_BYTE_W +: `CP_BYTE_W] <= next_coords[i];
					end
				end else begin
					slot <= slot + 1'b1;
				end
			end
		end
	end

endmodule

// ==== design/cone_point_unit.sv ====
module cone_point_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   row_valid,
	input  cone_point_pkg::lanes_t matrix_lanes,
	input  cone_point_pkg::lanes_t vector_lanes,
	input  cone_point_pkg::data_t  hat_value,
	input  cone_point_pkg::data_t  prime_value,
	input  cone_point_pkg::num_t   diagonal,
	output cone_point_pkg::point_t point_word,
	output logic                   point_valid,
	output cone_point_pkg::count_t point_count
);

	cone_point_pkg::data_t outer_sum;
	cone_point_pkg::data_t summand;
	cone_point_pkg::num_t  diag_aligned; // two cycles behind the input
	logic                  sum_valid;

	// multiply and adder tree
	row_dot_product u_row_dot_product (
		.clk          (clk),
		.reset        (reset),
		.row_valid    (row_valid),
		.matrix_lanes (matrix_lanes),
		.vector_lanes (vector_lanes),
		.diagonal     (diagonal),
		.outer_sum    (outer_sum),
		.diagonal_out (diag_aligned),
		.sum_valid    (sum_valid)
	);

	// runs beside the dot product
	summand_multiplier u_summand_multiplier (
		.clk         (clk),
		.hat_value   (hat_value),
		.prime_value (prime_value),
		.summand     (summand)
	);

	// numerator, floor divide and point packing
	point_divider u_point_divider (
		.clk         (clk),
		.reset       (reset),
		.sum_valid   (sum_valid),
		.outer_sum   (outer_sum),
		.summand     (summand),
		.diagonal    (diag_aligned),
		.point_word  (point_word),
		.point_valid (point_valid),
		.point_count (point_count)
	);

endmodule

// ==== test/cone_point_assertions.sv ====
module cone_point_assertions (
	input logic clk,
	input logic reset,
	input logic row_valid,
	input logic point_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	int         fail_count = 0;
	logic [3:0] row_slot; // rows seen in the current point
	logic       eleventh_row;

	assign eleventh_row = row_valid && (row_slot == 4'd10);

	always_ff @(posedge clk) begin
		if (reset) begin
			row_slot <= '0;
		end else if (row_valid) begin
			row_slot <= eleventh_row ? 4'd0 : row_slot + 4'd1;
		end
	end

	// one pulse per point and never two cycles long
	single_pulse: assert property (@(posedge clk) disable iff (reset)
		point_valid |=> !point_valid)
	else begin
		fail_count++;
		$error("point_valid high in two cycles in a row");
	end

	quiet_in_reset: assert property (@(posedge clk) reset |=> !point_valid)
	else begin
		fail_count++;
		$error("point_valid high during reset");
	end

	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !point_valid)
	else begin
		fail_count++;
		$error("point_valid high in the cycle after reset");
	end

	// seen rising at the third edge after the sampling edge
	pulse_follows_row: assert property (@(posedge clk) disable iff (reset)
		eleventh_row |-> ##3 $rose(point_valid))
	else begin
		fail_count++;
		$error("point_valid missing three cycles after the eleventh row");
	end

	pulse_has_row: assert property (@(posedge clk) disable iff (reset)
		point_valid |-> $past(eleventh_row, 3))
	else begin
		fail_count++;
		$error("point_valid without an eleventh row before it");
	end

endmodule

// ==== test/cone_point_checker.sv ====
`include "cone_point_cfg.svh"

module cone_point_checker (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   row_valid,
	input  cone_point_pkg::lanes_t matrix_lanes,
	input  cone_point_pkg::lanes_t vector_lanes,
	input  cone_point_pkg::data_t  hat_value,
	input  cone_point_pkg::data_t  prime_value,
	input  cone_point_pkg::num_t   diagonal,
	input  cone_point_pkg::point_t point_word,
	input  logic                   point_valid,
	input  cone_point_pkg::count_t point_count,
	output int                     error_count,
	output int                     points_checked
);

	timeunit 1ns;
	timeprecision 1ps;

	cone_point_pkg::point_t expected_q [$];
	cone_point_pkg::point_t building;
	cone_point_pkg::point_t exp_word;
	cone_point_pkg::point_t held_word;
	cone_point_pkg::count_t held_count;
	int                     slot;
	int                     errors = 0;
	int                     checked = 0;

	assign error_count    = errors;
	assign points_checked = checked;

	// expected coordinate byte of one row
	function automatic cone_point_pkg::coord_t ref_coord(
		input cone_point_pkg::lanes_t m,
		input cone_point_pkg::lanes_t v,
		input cone_point_pkg::data_t  hat,
		input cone_point_pkg::data_t  prime,
		input cone_point_pkg::num_t   diag
	);
		cone_point_pkg::data_t acc;
		cone_point_pkg::num_t  n40;
		longint                n;
		longint                d;
		longint                q;
		acc = hat * prime; // summand
		for (int i = 0; i < `CP_LANES; i++) begin
			acc = acc + m[i] * v[i];
		end
		n40 = acc[`CP_NUM_W-1:0];
		n = n40;
		d = diag;
		if (d < 0) begin // fold the sign into the numerator
			n = -n;
			d = -d;
		end
		if (n >= 0)
			q = n / d;
		else
			q = -((-n + d - 1) / d); // round away from zero for negatives
		return q[`CP_BYTE_W-1:0];
	endfunction

	// build expected points from the sampled rows
	always @(posedge clk) begin
		if (reset) begin
			slot = 0;
			building = '0;
		end else if (row_valid) begin
			building[slot*`CP_BYTE_W +: `CP_BYTE_W] =
				ref_coord(matrix_lanes, vector_lanes, hat_value, prime_value, diagonal);
			slot++;
			if (slot == `CP_COORDS) begin
				expected_q.push_back(building);
				building = '0;
				slot = 0;
			end
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (reset) begin
			held_word = '0;
			held_count = '0;
		end else if (point_valid) begin
			if (expected_q.size() == 0) begin
				$display("point pulse at %0t with no point pending", $time);
				errors++;
			end else begin
				exp_word = expected_q.pop_front();
				checked++;
				if (point_word !== exp_word) begin
					$display("CHECK FAILED at %0t: point %0d word %h, expected %h",
						$time, checked, point_word, exp_word);
					errors++;
				end
				if (point_count !== cone_point_pkg::count_t'(checked)) begin
					$display("CHECK FAILED at %0t: point_count %0d, expected %0d",
						$time, point_count, checked);
					errors++;
				end
			end
			held_word = point_word;
			held_count = point_count;
		end else if (point_word !== held_word || point_count !== held_count) begin
			$display("CHECK FAILED at %0t: point outputs changed without a pulse", $time);
			errors++;
			held_word = point_word;
			held_count = point_count;
		end
	end

endmodule

// ==== test/cone_point_tb.sv ====
`include "cone_point_cfg.svh"

module cone_point_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int POINTS_TOTAL = 11;
	localparam int ROWS_TOTAL = POINTS_TOTAL * `CP_COORDS;
	localparam int GAPS_MAX = 3 * `CP_COORDS * 1 + 5 * `CP_COORDS * 3; // idles of phases two and three
	localparam int CYCLE_LIMIT = 5 + 2 + ROWS_TOTAL + GAPS_MAX + 40;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   row_valid;
	cone_point_pkg::lanes_t matrix_lanes;
	cone_point_pkg::lanes_t vector_lanes;
	cone_point_pkg::data_t  hat_value;
	cone_point_pkg::data_t  prime_value;
	cone_point_pkg::num_t   diagonal;
	cone_point_pkg::point_t point_word;
	logic                   point_valid;
	cone_point_pkg::count_t point_count;
	int                     seed = 72817;
	int                     cycle_count = 0;
	int                     check_errors;
	int                     points_checked;

	always #20 clk = ~clk;

	cone_point_unit DUT (.*);

	cone_point_checker point_checker (
		.error_count    (check_errors),
		.points_checked (points_checked),
		.*
	);

	bind cone_point_unit cone_point_assertions assertions_inst (
		.clk         (clk),
		.reset       (reset),
		.row_valid   (row_valid),
		.point_valid (point_valid)
	);

	function automatic cone_point_pkg::data_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// kind 0 small positive, 1 negative numerators, 2 full range
	task automatic load_row(input int kind);
		cone_point_pkg::num_t mag;
		@(negedge clk);
		for (int i = 0; i < `CP_LANES; i++) begin
			case (kind)
				0: begin
					matrix_lanes[i] = $random(seed) & 15;
					vector_lanes[i] = $random(seed) & 15;
				end
				1: begin
					matrix_lanes[i] = $random(seed) & 3;
					vector_lanes[i] = $random(seed) & 3;
				end
				default: begin
					matrix_lanes[i] = rand_word();
					vector_lanes[i] = rand_word();
				end
			endcase
		end
		case (kind)
			0: begin
				hat_value = $random(seed) & 31;
				prime_value = $random(seed) & 31;
				diagonal = ($random(seed) & 15) + 1;
			end
			1: begin
				hat_value = ($random(seed) & 7) + 1;
				prime_value = -(cone_point_pkg::data_t'(($unsigned($random(seed)) % 2000) + 1));
				mag = ($random(seed) & 63) + 1;
				diagonal = ($random(seed) & 1) ? -mag : mag;
			end
			default: begin
				hat_value = rand_word();
				prime_value = rand_word();
				mag = ($random(seed) & 32'hfffff) + 1;
				diagonal = ($random(seed) & 1) ? -mag : mag;
			end
		endcase
		row_valid = 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			row_valid = 1'b0;
		end
	endtask

	task automatic send_point(input int kind, input int max_gap);
		for (int r = 0; r < `CP_COORDS; r++) begin
			load_row(kind);
			if (max_gap > 0)
				idle_cycles($unsigned($random(seed)) % (max_gap + 1));
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, only %0d of %0d points seen",
				cycle_count, points_checked, POINTS_TOTAL);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int assert_errors;
		reset = 1'b1;
		row_valid = 1'b0;
		matrix_lanes = '0;
		vector_lanes = '0;
		hat_value = '0;
		prime_value = '0;
		diagonal = 40'sd1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		idle_cycles(2);
		repeat (3) send_point(0, 0); // back to back
		repeat (3) send_point(1, 1);
		repeat (5) send_point(2, 3); // random idle gaps
		idle_cycles(1);
		wait (points_checked == POINTS_TOTAL);
		repeat (4) @(negedge clk); // outputs must hold after the last pulse
		assert_errors = DUT.assertions_inst.fail_count;
		$display("%0d points checked, %0d check errors, %0d assertion errors",
			points_checked, check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== cone_point_unit.f ====
+incdir+design
design/cone_point_pkg.sv
design/row_dot_product.sv
design/summand_multiplier.sv
design/point_divider.sv
design/cone_point_unit.sv
test/cone_point_assertions.sv
test/cone_point_checker.sv
test/cone_point_tb.sv

// ==== Bender.yml ====
package:
  name: cone_point_unit

sources:
  - include_dirs:
      - design
    files:
      - design/cone_point_pkg.sv
      - design/row_dot_product.sv
      - design/summand_multiplier.sv
      - design/point_divider.sv
      - design/cone_point_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/cone_point_assertions.sv
      - test/cone_point_checker.sv
      - test/cone_point_tb.sv
